// ==== Bender.yml ====
package:
  name: row_process_element

sources:
  - hdl/ldpc_pkg.sv
  - hdl/cnu_input_stage.sv
  - hdl/cnu_min_finder.sv
  - hdl/cnu_c2v_gen.sv
  - hdl/vnu_partial.sv
  - hdl/row_process_element.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_row_process_element.sv

// ==== files.f ====
+incdir+verif
hdl/ldpc_pkg.sv
hdl/cnu_input_stage.sv
hdl/cnu_min_finder.sv
hdl/cnu_c2v_gen.sv
hdl/vnu_partial.sv
hdl/row_process_element.sv
verif/tb_row_process_element.sv

// ==== hdl/cnu_c2v_gen.sv ====
`timescale 1ns/1ps

module cnu_c2v_gen import ldpc_pkg::*; (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic [MAG_SIZE-1:0]  min1,
	input  logic [MAG_SIZE-1:0]  min2,
	input  logic [IDX_W-1:0]     min_idx,
	input  logic                 sign_prod,
	input  logic [CN_DEGREE-1:0] signs_d,
	output msg_t                 c2v_new [CN_DEGREE]  // registered per edge
);

	// next value for every edge
	msg_t c2v_c [CN_DEGREE];

	// extrinsic rule leaves the edge's own contribution out
	// the edge that holds min1 sees min2 and every other edge sees min1
	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++) begin
			c2v_c[i].sm.mag  = (min_idx == IDX_W'(i)) ? min2 : min1;
			c2v_c[i].sm.sign = sign_prod ^ signs_d[i]; // xor out own sign
		end
	end

	// fourth check node stage
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int i = 0; i < CN_DEGREE; i++)
				c2v_new[i] <= '0;
		end else begin
			for (int i = 0; i < CN_DEGREE; i++)
				c2v_new[i] <= c2v_c[i];
		end
	end

endmodule

// ==== hdl/cnu_input_stage.sv ====
`timescale 1ns/1ps

module cnu_input_stage import ldpc_pkg::*; (
	input  logic read_clk,
	input  logic rstn,
	input  logic v2c_src,                    // high on the first iteration to take channel values
	input  msg_t ch_msg      [CN_DEGREE],
	input  msg_t v2c_in      [CN_DEGREE],
	output msg_t cnu_din     [CN_DEGREE],    // to the check node in the same cycle
	output msg_t v2c_delayed [CN_DEGREE]     // same words CNU_FUNC_CYCLE cycles later
);

	// one shift chain per edge with the newest row in tap 0
	msg_t dly [CN_DEGREE][CNU_FUNC_CYCLE];

	// source mux without a register so the row enters the check node right away
	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++)
			cnu_din[i].raw = v2c_src ? ch_msg[i].raw : v2c_in[i].raw;
	end

	// keeps the selected word of each row in step with the check node pipe
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int i = 0; i < CN_DEGREE; i++)
				for (int s = 0; s < CNU_FUNC_CYCLE; s++)
					dly[i][s] <= '0;
		end else begin
			for (int i = 0; i < CN_DEGREE; i++) begin
				dly[i][0] <= cnu_din[i];  // row enters together with stage one
				for (int s = 1; s < CNU_FUNC_CYCLE; s++)
					dly[i][s] <= dly[i][s-1];
			end
		end
	end

	// last tap lines up with c2v_new of the same row
	always_comb begin
		for (int i = 0; i < CN_DEGREE; i++)
			v2c_delayed[i] = dly[i][CNU_FUNC_CYCLE-1];
	end

endmodule

// ==== hdl/cnu_min_finder.sv ====
`timescale 1ns/1ps

module cnu_min_finder import ldpc_pkg::*; (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  msg_t                 cnu_din [CN_DEGREE],
	output logic [MAG_SIZE-1:0]  min1,       // smallest magnitude of the row
	output logic [MAG_SIZE-1:0]  min2,       // second smallest that equals min1 on a tie
	output logic [IDX_W-1:0]     min_idx,    // edge holding min1 with the lowest winning a tie
	output logic                 sign_prod,  // xor of all ten signs
	output logic [CN_DEGREE-1:0] signs_d     // per-edge signs aligned with the minima
);

	// stage one registers the inputs
	msg_t din_q [CN_DEGREE];

	// stage two keeps per-half results for edges 0..4 and 5..9
	logic [MAG_SIZE-1:0]  hm1_c  [2];
	logic [MAG_SIZE-1:0]  hm2_c  [2];
	logic [IDX_W-1:0]     hidx_c [2];
	logic [MAG_SIZE-1:0]  hm1_q  [2];
	logic [MAG_SIZE-1:0]  hm2_q  [2];
	logic [IDX_W-1:0]     hidx_q [2];
	logic [CN_DEGREE-1:0] signs_q;

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int i = 0; i < CN_DEGREE; i++)
				din_q[i] <= '0;
		end else begin
			for (int i = 0; i < CN_DEGREE; i++)
				din_q[i] <= cnu_din[i];
		end
	end

	// linear scan over five edges per half
	always_comb begin : half_scan
		logic [MAG_SIZE-1:0] m;
		m = '0;
		for (int h = 0; h < 2; h++) begin
			hm1_c[h]  = MAG_SIZE'(MAG_MAX);    // start at the top so any edge wins
			hm2_c[h]  = MAG_SIZE'(MAG_MAX);
			hidx_c[h] = IDX_W'(h * (CN_DEGREE / 2));
			for (int k = 0; k < CN_DEGREE / 2; k++) begin
				m = din_q[h * (CN_DEGREE / 2) + k].sm.mag;
				if (m < hm1_c[h]) begin     // strict so the earlier edge keeps a tie
					hm2_c[h]  = hm1_c[h];
					hm1_c[h]  = m;
					hidx_c[h] = IDX_W'(h * (CN_DEGREE / 2) + k);
				end else if (m < hm2_c[h]) begin
					hm2_c[h] = m;             // equal to min1 lands here too
				end
			end
		end
	end

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			for (int h = 0; h < 2; h++) begin
				hm1_q[h]  <= '0;
				hm2_q[h]  <= '0;
				hidx_q[h] <= '0;
			end
			signs_q <= '0;
		end else begin
			for (int h = 0; h < 2; h++) begin
				hm1_q[h]  <= hm1_c[h];
				hm2_q[h]  <= hm2_c[h];
				hidx_q[h] <= hidx_c[h];
			end
			for (int i = 0; i < CN_DEGREE; i++)
				signs_q[i] <= din_q[i].sm.sign;
		end
	end

	// stage three merges the halves
	// half 0 wins a tie so the lowest index survives
	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			min1      <= '0;
			min2      <= '0;
			min_idx   <= '0;
			sign_prod <= 1'b0;
			signs_d   <= '0;
		end else begin
			if (hm1_q[0] <= hm1_q[1]) begin
				min1    <= hm1_q[0];
				min_idx <= hidx_q[0];
				min2    <= (hm2_q[0] < hm1_q[1]) ? hm2_q[0] : hm1_q[1];
			end else begin
				min1    <= hm1_q[1];
				min_idx <= hidx_q[1];
				min2    <= (hm1_q[0] < hm2_q[1]) ? hm1_q[0] : hm2_q[1];
			end
			sign_prod <= ^signs_q;
			signs_d   <= signs_q;           // each edge strips its own sign later
		end
	end

endmodule

// ==== hdl/ldpc_pkg.sv ====
package ldpc_pkg;

	localparam int QUAN_SIZE      = 4;  // message word width
	localparam int MAG_SIZE       = 3;  // magnitude part of a message
	localparam int MAG_MAX        = 7;  // saturation level
	localparam int CN_DEGREE      = 10; // edges on one check row
	localparam int CNU_FUNC_CYCLE = 4;  // check node pipeline depth
	localparam int IDX_W          = 4;  // edge index width
	localparam int SUM_W          = 6;  // sum of three 3-bit magnitudes plus sign

	// sign-magnitude view where sign 1 is negative
	typedef struct packed {
		logic                sign;
		logic [MAG_SIZE-1:0] mag;
	} msg_sm_t;

	// the select path moves raw words while the arithmetic looks at sign and magnitude
	typedef union packed {
		logic [QUAN_SIZE-1:0] raw;
		msg_sm_t              sm;
	} msg_t;

	// sign-magnitude to two's complement with -0 read as 0
	function automatic logic signed [SUM_W-1:0] sm_to_int(msg_t m);
		logic signed [SUM_W-1:0] v;
		v = signed'({{(SUM_W-MAG_SIZE){1'b0}}, m.sm.mag});
		return m.sm.sign ? -v : v;
	endfunction

	// clip to +/-MAG_MAX and re-encode; zero keeps a positive sign
	function automatic msg_t int_to_sm(logic signed [SUM_W-1:0] v);
		msg_t                    m;
		logic signed [SUM_W-1:0] a;
		a = (v < 0) ? -v : v;
		if (a > MAG_MAX)
			a = SUM_W'(MAG_MAX);
		m.sm.sign = (v < 0);
		m.sm.mag  = a[MAG_SIZE-1:0];
		return m;
	endfunction

endpackage

// ==== hdl/row_process_element.sv ====
`timescale 1ns/1ps

module row_process_element import ldpc_pkg::*; (
	input  logic                 read_clk,
	input  logic                 rstn,
	input  logic                 v2c_src,                  // high on the first iteration
	input  msg_t                 ch_msg        [CN_DEGREE],
	input  msg_t                 v2c_in        [CN_DEGREE],
	input  msg_t                 post_c2v      [CN_DEGREE],  // presented four cycles after the row
	output msg_t                 v2c_out       [CN_DEGREE],
	output logic [CN_DEGREE-1:0] hard_decision
);

	msg_t                 cnu_din     [CN_DEGREE];  // selected check node inputs
	msg_t                 v2c_delayed [CN_DEGREE];  // same inputs aligned with c2v_new
	msg_t                 c2v_new     [CN_DEGREE];
	logic [MAG_SIZE-1:0]  min1;
	logic [MAG_SIZE-1:0]  min2;
	logic [IDX_W-1:0]     min_idx;
	logic                 sign_prod;
	logic [CN_DEGREE-1:0] signs_d;

	// source mux and delay line
	cnu_input_stage u_input (
		.read_clk    (read_clk),
		.rstn        (rstn),
		.v2c_src     (v2c_src),
		.ch_msg      (ch_msg),
		.v2c_in      (v2c_in),
		.cnu_din     (cnu_din),
		.v2c_delayed (v2c_delayed)
	);

	// check node stages one to three
	cnu_min_finder u_min (
		.read_clk  (read_clk),
		.rstn      (rstn),
		.cnu_din   (cnu_din),
		.min1      (min1),
		.min2      (min2),
		.min_idx   (min_idx),
		.sign_prod (sign_prod),
		.signs_d   (signs_d)
	);

	// check node stage four
	cnu_c2v_gen u_c2v (
		.read_clk  (read_clk),
		.rstn      (rstn),
		.min1      (min1),
		.min2      (min2),
		.min_idx   (min_idx),
		.sign_prod (sign_prod),
		.signs_d   (signs_d),
		.c2v_new   (c2v_new)
	);

	// one partial variable node per edge as the fifth pipeline stage
	for (genvar i = 0; i < CN_DEGREE; i++) begin : g_vnu
		vnu_partial u_vnu (
			.read_clk      (read_clk),
			.rstn          (rstn),
			.ch_msg        (ch_msg[i]),
			.post_c2v      (post_c2v[i]),
			.c2v_new       (c2v_new[i]),
			.v2c_delayed   (v2c_delayed[i]),
			.v2c_out       (v2c_out[i]),
			.hard_decision (hard_decision[i])
		);
	end

endmodule

// ==== hdl/vnu_partial.sv ====
`timescale 1ns/1ps

module vnu_partial import ldpc_pkg::*; (
	input  logic read_clk,
	input  logic rstn,
	input  msg_t ch_msg,         // channel value of this variable
	input  msg_t post_c2v,       // check message from the previous layer
	input  msg_t c2v_new,        // check message just produced by this row
	input  msg_t v2c_delayed,    // this row's own old message from the delay line
	output msg_t v2c_out,        // extrinsic message for the next layer
	output logic hard_decision   // 1 means bit estimate is 1
);

	// two's complement copies of the inputs
	logic signed [SUM_W-1:0] ch_val;
	logic signed [SUM_W-1:0] post_val;
	logic signed [SUM_W-1:0] new_val;
	logic signed [SUM_W-1:0] old_val;

	// at most 3*MAG_MAX which fits SUM_W
	logic signed [SUM_W-1:0] ext_sum;
	logic signed [SUM_W-1:0] app_sum;

	assign ch_val   = sm_to_int(ch_msg);
	assign post_val = sm_to_int(post_c2v);
	assign new_val  = sm_to_int(c2v_new);
	assign old_val  = sm_to_int(v2c_delayed);

	// channel plus both layers' check messages
	assign ext_sum = ch_val + post_val + new_val;

	// a-posteriori value seen on this edge
	assign app_sum = old_val + new_val;

	always_ff @(posedge read_clk) begin
		if (!rstn) begin
			v2c_out       <= '0;
			hard_decision <= 1'b0;
		end else begin
			v2c_out       <= int_to_sm(ext_sum); // clipped to +/-MAG_MAX
			hard_decision <= app_sum[SUM_W-1];   // negative sum decides a 1
		end
	end

endmodule

// ==== verif/rpe_model.svh ====
`ifndef RPE_MODEL_SVH
`define RPE_MODEL_SVH

// sign-magnitude word as a plain integer with negative zero read as zero
function automatic int sm_value(msg_t m);
	int v;
	v = int'(m.sm.mag);
	if (m.sm.sign)
		v = -v;
	return v;
endfunction

// clip to +/-MAG_MAX and give zero a sign of 0
function automatic msg_t saturate_sm(int v);
	msg_t m;
	int   a;
	a = (v < 0) ? -v : v;
	if (a > MAG_MAX)
		a = MAG_MAX;
	m.sm.sign = (v < 0);
	m.sm.mag  = MAG_SIZE'(a);
	return m;
endfunction

// min-sum check message for edge e
// smallest magnitude and xor of signs over the nine other edges
function automatic msg_t min_sum_edge(logic [CN_DEGREE*QUAN_SIZE-1:0] row, int e);
	msg_t                m;
	msg_t                res;
	logic [MAG_SIZE-1:0] mag;
	logic                sgn;
	mag = MAG_SIZE'(MAG_MAX);
	sgn = 1'b0;
	for (int j = 0; j < CN_DEGREE; j++) begin
		m.raw = row[j*QUAN_SIZE +: QUAN_SIZE];
		if (j != e) begin
			if (m.sm.mag < mag)
				mag = m.sm.mag;
			sgn = sgn ^ m.sm.sign; // sign bit counts even on a zero magnitude
		end
	end
	res.sm.sign = sgn;
	res.sm.mag  = mag;
	return res;
endfunction

// bit estimate from old message plus new check message
function automatic logic hard_bit(msg_t old_m, msg_t c2v_m);
	return (sm_value(old_m) + sm_value(c2v_m)) < 0;
endfunction

`endif

// ==== verif/tb_row_process_element.sv ====
`timescale 1ns/1ps

module tb_row_process_element import ldpc_pkg::*; ();

	localparam int N_IDLE   = 5;    // zero-output check after reset
	localparam int N_LOW    = 300;
	localparam int N_HIGH   = 200;
	localparam int N_MIX    = 300;
	localparam int N_CORNER = 100;
	localparam int DRAIN    = 5;    // pipeline latency that flushes the last rows
	localparam int HIST     = 8;    // model history slots beyond the latency
	localparam int TIMEOUT_CYCLES = 8 + N_IDLE + N_LOW + N_HIGH + N_MIX + N_CORNER
		+ 4 * DRAIN + 20;
	localparam int MODE_LOW    = 0;
	localparam int MODE_HIGH   = 1;
	localparam int MODE_MIX    = 2;
	localparam int MODE_CORNER = 3;

	logic                 read_clk;
	logic                 rstn;
	logic                 v2c_src;
	msg_t                 ch_msg   [CN_DEGREE];
	msg_t                 v2c_in   [CN_DEGREE];
	msg_t                 post_c2v [CN_DEGREE];
	msg_t                 v2c_out  [CN_DEGREE];
	logic [CN_DEGREE-1:0] hard_decision;

	msg_t nxt_ch   [CN_DEGREE]; // staged values for the next drive
	msg_t nxt_v2c  [CN_DEGREE];
	msg_t nxt_post [CN_DEGREE];

	logic [CN_DEGREE*QUAN_SIZE-1:0] sel_hist [HIST]; // check node inputs per row
	logic [CN_DEGREE*QUAN_SIZE-1:0] c2v_hist [HIST]; // model check messages per row
	bit                             row_valid [HIST];

	logic [CN_DEGREE*QUAN_SIZE-1:0] exp_v2c_q [$]; // scoreboard
	logic [CN_DEGREE-1:0]           exp_hd_q  [$];

	integer seed;
	int     step_cnt;
	int     cycle_cnt;
	int     err_cnt;
	int     chk_cnt;
	int     test_cnt;

	`include "rpe_model.svh"

	row_process_element dut_i (
		.read_clk      (read_clk),
		.rstn          (rstn),
		.v2c_src       (v2c_src),
		.ch_msg        (ch_msg),
		.v2c_in        (v2c_in),
		.post_c2v      (post_c2v),
		.v2c_out       (v2c_out),
		.hard_decision (hard_decision)
	);

	initial begin
		read_clk = 1'b0;
		forever #5 read_clk = ~read_clk;
	end

	// hang guard
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge read_clk);
			cycle_cnt++;
		end
		$display("run timed out after %0d cycles without finishing the tests", cycle_cnt);
		$display("Verification failed");
		$finish;
	end

	function automatic msg_t random_msg();
		msg_t m;
		m.raw = QUAN_SIZE'($random(seed));
		return m;
	endfunction

	// random levels on every input while rstn is low
	task automatic drive_random_inputs();
		v2c_src = 1'($random(seed));
		for (int e = 0; e < CN_DEGREE; e++) begin
			ch_msg[e]   = random_msg();
			v2c_in[e]   = random_msg();
			post_c2v[e] = random_msg();
		end
	endtask

	task automatic check_msg(input string name, input msg_t got, input msg_t exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t %s got %h expected %h", $time, name, got.raw, exp.raw);
		end
	endtask

	task automatic check_hd(input logic [CN_DEGREE-1:0] got, input logic [CN_DEGREE-1:0] exp);
		chk_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("ERR %0t hard_decision got %b expected %b", $time, got, exp);
		end
	endtask

	task automatic compare_row(input logic [CN_DEGREE*QUAN_SIZE-1:0] exp_v2c,
		input logic [CN_DEGREE-1:0] exp_hd);
		msg_t e_m;
		for (int e = 0; e < CN_DEGREE; e++) begin
			e_m.raw = exp_v2c[e*QUAN_SIZE +: QUAN_SIZE];
			check_msg($sformatf("v2c_out[%0d]", e), v2c_out[e], e_m);
		end
		check_hd(hard_decision, exp_hd);
	endtask

	// one clock checks the row from five cycles back, drives and then updates the model
	task automatic advance_cycle(input logic src, input bit valid);
		int                             slot;
		int                             old_slot;
		logic [CN_DEGREE*QUAN_SIZE-1:0] exp_v2c;
		logic [CN_DEGREE-1:0]           exp_hd;
		logic [CN_DEGREE*QUAN_SIZE-1:0] sel;
		msg_t                           old_m;
		msg_t                           c2v_m;
		msg_t                           out_m;
		@(posedge read_clk);
		#1;
		if (exp_v2c_q.size() > 0)
			compare_row(exp_v2c_q.pop_front(), exp_hd_q.pop_front());
		v2c_src = src;
		for (int e = 0; e < CN_DEGREE; e++) begin
			ch_msg[e]   = nxt_ch[e];
			v2c_in[e]   = nxt_v2c[e];
			post_c2v[e] = nxt_post[e];
		end
		slot     = step_cnt % HIST;
		old_slot = (step_cnt + HIST - 4) % HIST; // row whose c2v is ready now
		if (row_valid[old_slot]) begin
			for (int e = 0; e < CN_DEGREE; e++) begin
				old_m.raw = sel_hist[old_slot][e*QUAN_SIZE +: QUAN_SIZE];
				c2v_m.raw = c2v_hist[old_slot][e*QUAN_SIZE +: QUAN_SIZE];
				out_m     = saturate_sm(sm_value(nxt_ch[e]) + sm_value(nxt_post[e])
					+ sm_value(c2v_m));  // ch and post as driven right now
				exp_v2c[e*QUAN_SIZE +: QUAN_SIZE] = out_m.raw;
				exp_hd[e] = hard_bit(old_m, c2v_m);
			end
			exp_v2c_q.push_back(exp_v2c);
			exp_hd_q.push_back(exp_hd);
		end
		for (int e = 0; e < CN_DEGREE; e++)
			sel[e*QUAN_SIZE +: QUAN_SIZE] = src ? nxt_ch[e].raw : nxt_v2c[e].raw;
		sel_hist[slot] = sel;
		for (int e = 0; e < CN_DEGREE; e++)
			c2v_hist[slot][e*QUAN_SIZE +: QUAN_SIZE] = min_sum_edge(sel, e);
		row_valid[slot] = valid;
		step_cnt++;
	endtask

	// fills the staged inputs for one row of the given kind
	task automatic gen_row(input int mode, input int idx, output logic src);
		int   low;
		int   a;
		int   b;
		logic s;
		for (int e = 0; e < CN_DEGREE; e++) begin
			nxt_ch[e]   = random_msg();
			nxt_v2c[e]  = random_msg();
			nxt_post[e] = random_msg();
		end
		case (mode)
			MODE_LOW:  src = 1'b0;
			MODE_HIGH: src = 1'b1;
			MODE_MIX:  src = 1'($random(seed));
			default: begin
				src = 1'b0;
				s   = 1'($random(seed));
				for (int e = 0; e < CN_DEGREE; e++) begin
					nxt_ch[e].sm.sign = s;          // ch and post both full scale with one sign
					nxt_ch[e].sm.mag  = MAG_SIZE'(MAG_MAX);
					nxt_post[e]       = nxt_ch[e];
				end
				if (idx % 2 == 0) begin
					s = 1'($random(seed));
					for (int e = 0; e < CN_DEGREE; e++) begin
						nxt_v2c[e].sm.sign = s;
						nxt_v2c[e].sm.mag  = MAG_SIZE'(MAG_MAX);
					end
				end else begin
					low = $unsigned($random(seed)) % (MAG_MAX + 1);
					for (int e = 0; e < CN_DEGREE; e++)
						nxt_v2c[e].sm.mag = MAG_SIZE'(low
							+ $unsigned($random(seed)) % (MAG_MAX + 1 - low));
					a = $unsigned($random(seed)) % CN_DEGREE;
					b = (a + 1 + $unsigned($random(seed)) % (CN_DEGREE - 1)) % CN_DEGREE;
					nxt_v2c[a].sm.mag = MAG_SIZE'(low); // two edges share the minimum
					nxt_v2c[b].sm.mag = MAG_SIZE'(low);
				end
			end
		endcase
	endtask

	task automatic run_test(input string name, input int mode, input int rows);
		int   errs_before;
		logic src;
		errs_before = err_cnt;
		for (int r = 0; r < rows; r++) begin
			gen_row(mode, r, src);
			advance_cycle(src, 1'b1);
		end
		for (int r = 0; r < DRAIN; r++) begin
			gen_row(mode, r, src);
			advance_cycle(src, 1'b0);   // unchecked filler while the last rows drain
		end
		if (exp_v2c_q.size() != 0) begin
			err_cnt++;
			$display("%s: %0d expected rows were never compared", name, exp_v2c_q.size());
		end
		test_cnt++;
		$display("%s done, %0d rows, %0d errors", name, rows, err_cnt - errs_before);
	endtask

	initial begin
		int errs_before;
		seed     = 58781;
		step_cnt = 0;
		err_cnt  = 0;
		chk_cnt  = 0;
		test_cnt = 0;
		rstn     = 1'b0;
		v2c_src  = 1'b0;
		for (int e = 0; e < CN_DEGREE; e++) begin
			ch_msg[e]   = '0;
			v2c_in[e]   = '0;
			post_c2v[e] = '0;
			nxt_ch[e]   = '0;
			nxt_v2c[e]  = '0;
			nxt_post[e] = '0;
		end
		for (int k = 0; k < HIST; k++)
			row_valid[k] = 1'b0;
		// busy inputs during reset leave nonzero rows in any stage that misses its reset
		repeat (7) begin
			@(posedge read_clk);
			#1;
			drive_random_inputs();
		end
		@(posedge read_clk);
		#1;
		rstn    = 1'b1;
		v2c_src = 1'b0;
		for (int e = 0; e < CN_DEGREE; e++) begin
			ch_msg[e]   = '0;
			v2c_in[e]   = '0;
			post_c2v[e] = '0;
		end

		errs_before = err_cnt; // outputs stay zero while nothing has come through
		for (int r = 0; r < N_IDLE; r++) begin
			advance_cycle(1'b0, 1'b0);
			for (int e = 0; e < CN_DEGREE; e++)
				check_msg($sformatf("v2c_out[%0d]", e), v2c_out[e], '0);
			check_hd(hard_decision, '0);
		end
		test_cnt++;
		$display("reset_zero done, %0d cycles, %0d errors", N_IDLE, err_cnt - errs_before);

		run_test("v2c_src_low", MODE_LOW, N_LOW);
		run_test("v2c_src_high", MODE_HIGH, N_HIGH);
		run_test("v2c_src_mixed", MODE_MIX, N_MIX);
		run_test("saturation_ties", MODE_CORNER, N_CORNER);

		$display("tests %0d, checks %0d, errors %0d", test_cnt, chk_cnt, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
